//--- build.f
ccis_pkg.sv
rsp_c0_if.sv
wr_credit_counter.sv
wr_rsp_fifo.sv
rsp_canonicalizer.sv
ccis_wires_to_mpf.sv
ccis_shim_chk.sv
tb_ccis_shim.sv

//--- Bender.yml
package:
  name: ccis_shim

sources:
  - ccis_pkg.sv
  - rsp_c0_if.sv
  - wr_credit_counter.sv
  - wr_rsp_fifo.sv
  - rsp_canonicalizer.sv
  - ccis_wires_to_mpf.sv
  - target: test
    files:
      - ccis_shim_chk.sv
      - tb_ccis_shim.sv

//--- tb_ccis_shim.sv
module tb_ccis_shim
    import ccis_pkg::*;
();

    logic     clk = 1'b0;
    logic     reset_n;
    t_rsp_hdr plat_c0_rx_hdr, plat_c1_rx_hdr, afu_c0_rx_hdr, afu_c1_rx_hdr;
    t_cl_data plat_c0_rx_data, afu_c0_rx_data, plat_c1_tx_data, afu_c1_tx_data;
    logic     plat_c0_rx_wr_valid, plat_c0_rx_rd_valid, plat_c0_rx_cfg_valid;
    logic     plat_c0_rx_umsg_valid, plat_c0_rx_intr_valid;
    logic     plat_c1_rx_wr_valid, plat_c1_rx_intr_valid;
    t_req_hdr plat_c0_tx_hdr, plat_c1_tx_hdr, afu_c0_tx_hdr, afu_c1_tx_hdr;
    logic     plat_c0_tx_rd_valid, plat_c1_tx_wr_valid, plat_c1_tx_intr_valid;
    logic     afu_c0_tx_rd_valid, afu_c1_tx_wr_valid, afu_c1_tx_intr_valid;
    logic     plat_c0_tx_alm_full, plat_c1_tx_alm_full, afu_c0_tx_alm_full, afu_c1_tx_alm_full;
    logic     afu_c0_rx_rd_valid, afu_c0_rx_cfg_valid, afu_c0_rx_umsg_valid;
    logic     afu_c0_rx_intr_valid, afu_c1_rx_wr_valid, afu_c1_rx_intr_valid;

    // ------------------------------------------------------------
    // Stimulus table, one row per cycle
    // ------------------------------------------------------------
    // c0 kind: 0 idle, 1 write, 2 read, 3 cfg, 4 umsg, 5 intr
    int c0_kind_tbl [40] = '{2, 3, 4, 5, 0, 2, 0, 3, 0, 4, 0, 5, 0, 2, 0, 0, 0, 1, 0, 1,
                             1, 1, 0, 0, 0, 2, 0, 3, 1, 1, 4, 0, 5, 1, 0, 0, 0, 0, 0, 0};
    int c1_kind_tbl [40] = '{0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                             1, 1, 1, 1, 2, 0, 0, 0, 0, 1, 0, 0, 2, 0, 0, 0, 0, 0, 0, 0};
    // tx kind: 0 idle, 1 c0 read, 2 write line I, 3 write line M, 4 intr
    // 5 is the write strobe carrying an intr type, which takes no slot
    int tx_kind_tbl [40] = '{1, 0, 1, 5, 2, 3, 4, 2, 3, 2, 3, 2, 3, 2, 3, 2, 3, 0, 0, 0,
                             0, 2, 0, 0, 0, 3, 0, 2, 0, 3, 0, 2, 0, 0, 0, 0, 0, 0, 0, 0};
    int af_tbl      [40] = '{0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                             0, 0, 0, 2, 2, 0, 0, 0, 1, 0, 0, 0, 3, 0, 0, 0, 0, 0, 0, 0};
    t_rsp_hdr c0_hdr_tbl [40], c1_hdr_tbl [40];         // Random tags, type from kind
    t_cl_data c0_data_tbl [40], tx_data_tbl [40];
    t_req_hdr tx_hdr_tbl [40];                          // Channel 1 request headers
    t_req_hdr c0_tx_hdr_tbl [40];                       // Channel 0 read headers

    logic [31:0] rng = 32'd71033;                       // Seed
    int       m_c0_kind = 0, m_c1_kind = 0, m_count = 0; // Model of the register stage
    t_rsp_hdr m_c0_hdr, m_c1_hdr;
    t_cl_data m_c0_data;
    t_mdata   moved_q [$];                              // Write tags waiting for channel 1
    int       moved_total = 0, moved_seen = 0;
    int       checks = 0, value_errors = 0, other_errors = 0;

    ccis_wires_to_mpf UUT (.*);

    always #10 clk = ~clk;                              // 20 unit period

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;                               // 32-bit xorshift
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic t_rsp_hdr make_rsp_hdr(t_rsp_type ty, t_mdata md);
        return {ty, md};
    endfunction

    function automatic t_rsp_type c0_rsp_type(int kind);
        case (kind)
            1:       return RSP_WRLINE;
            3:       return RSP_CFG;
            4:       return RSP_UMSG;
            5:       return RSP_INTR;
            default: return RSP_RDLINE;
        endcase
    endfunction

    function automatic t_req_type tx_req_type(int kind);
        case (kind)
            2:       return REQ_WRLINE_I;
            3:       return REQ_WRLINE_M;
            4, 5:    return REQ_INTR;
            default: return REQ_RDLINE;
        endcase
    endfunction

    task automatic check_rsp_hdr(string name, t_rsp_hdr exp, t_rsp_hdr act);
        checks++;
        if (act !== exp)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_req_hdr(string name, t_req_hdr exp, t_req_hdr act);
        checks++;
        if (act !== exp)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_data(string name, t_cl_data exp, t_cl_data act);
        checks++;
        if (act !== exp)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic build_table();
        for (int r = 0; r < $size(c0_kind_tbl); r++)
        begin
            c0_hdr_tbl[r]  = make_rsp_hdr(c0_rsp_type(c0_kind_tbl[r]), t_mdata'(next_random()));
            c0_data_tbl[r] = {next_random(), next_random()};
            c1_hdr_tbl[r]  = make_rsp_hdr((c1_kind_tbl[r] == 2) ? RSP_INTR : RSP_WRLINE,
                                          t_mdata'(next_random()));
            tx_hdr_tbl[r]  = {tx_req_type(tx_kind_tbl[r]), next_random(), t_mdata'(next_random())};
            tx_data_tbl[r] = {next_random(), next_random()};
            c0_tx_hdr_tbl[r] = {REQ_RDLINE, next_random(), t_mdata'(next_random())};
        end
    endtask

    task automatic apply_row(int r);
        plat_c0_rx_hdr        = c0_hdr_tbl[r];
        plat_c0_rx_data       = c0_data_tbl[r];
        plat_c0_rx_wr_valid   = (c0_kind_tbl[r] == 1);
        plat_c0_rx_rd_valid   = (c0_kind_tbl[r] == 2);
        plat_c0_rx_cfg_valid  = (c0_kind_tbl[r] == 3);
        plat_c0_rx_umsg_valid = (c0_kind_tbl[r] == 4);
        plat_c0_rx_intr_valid = (c0_kind_tbl[r] == 5);
        plat_c1_rx_hdr        = c1_hdr_tbl[r];
        plat_c1_rx_wr_valid   = (c1_kind_tbl[r] == 1);
        plat_c1_rx_intr_valid = (c1_kind_tbl[r] == 2);
        afu_c0_tx_hdr         = c0_tx_hdr_tbl[r];       // Differs from channel 1 header
        afu_c0_tx_rd_valid    = (tx_kind_tbl[r] == 1);
        afu_c1_tx_hdr         = tx_hdr_tbl[r];
        afu_c1_tx_data        = tx_data_tbl[r];
        afu_c1_tx_wr_valid    = (tx_kind_tbl[r] == 2) || (tx_kind_tbl[r] == 3) ||
                                (tx_kind_tbl[r] == 5);
        afu_c1_tx_intr_valid  = (tx_kind_tbl[r] == 4);
        plat_c0_tx_alm_full   = af_tbl[r][0];
        plat_c1_tx_alm_full   = af_tbl[r][1];
    endtask

    // ------------------------------------------------------------
    // Reference model, one clock edge with row r applied
    // ------------------------------------------------------------
    task automatic advance_model(int r);
        logic replay;
        logic rx_wr;
        logic wr_req;
        replay = (moved_q.size() != 0) && (m_c1_kind == 0);  // Channel 1 free for a tag
        rx_wr  = replay || (m_c1_kind == 1);
        wr_req = (tx_kind_tbl[r] == 2) || (tx_kind_tbl[r] == 3);  // Intr requests take no slot
        if (wr_req && !rx_wr)
        begin
            m_count++;
        end
        else if (!wr_req && rx_wr)
        begin
            m_count--;
        end
        if (replay)
        begin
            void'(moved_q.pop_front());
        end
        if (m_c0_kind == 1)
        begin
            moved_q.push_back(m_c0_hdr[MDATA_WIDTH-1:0]);  // Enqueued one edge after capture
            moved_total++;
        end
        m_c0_kind = c0_kind_tbl[r];
        m_c0_hdr  = c0_hdr_tbl[r];
        m_c0_data = c0_data_tbl[r];
        m_c1_kind = c1_kind_tbl[r];
        m_c1_hdr  = c1_hdr_tbl[r];
    endtask

    task automatic check_outputs(int r);
        string    tag;
        logic     replay;
        t_rsp_hdr moved_hdr;
        tag    = $sformatf("row %0d", r);
        replay = (moved_q.size() != 0) && (m_c1_kind == 0);
        check_bit({tag, " c0 rd_valid"}, m_c0_kind == 2, afu_c0_rx_rd_valid);
        check_bit({tag, " c0 cfg_valid"}, m_c0_kind == 3, afu_c0_rx_cfg_valid);
        check_bit({tag, " c0 umsg_valid"}, m_c0_kind == 4, afu_c0_rx_umsg_valid);
        check_bit({tag, " c0 intr_valid"}, m_c0_kind == 5, afu_c0_rx_intr_valid);
        if (m_c0_kind >= 2)                             // Payload only counts with a strobe
        begin
            check_rsp_hdr({tag, " c0 rx hdr"}, m_c0_hdr, afu_c0_rx_hdr);
            check_data({tag, " c0 rx data"}, m_c0_data, afu_c0_rx_data);
        end
        check_bit({tag, " c1 wr_valid"}, replay || (m_c1_kind == 1), afu_c1_rx_wr_valid);
        check_bit({tag, " c1 intr_valid"}, !replay && (m_c1_kind == 2), afu_c1_rx_intr_valid);
        if (replay)
        begin
            moved_hdr = make_rsp_hdr(RSP_WRLINE, moved_q[0]);
            check_rsp_hdr({tag, " c1 moved hdr"}, moved_hdr, afu_c1_rx_hdr);
            if ((afu_c1_rx_wr_valid === 1'b1) && (afu_c1_rx_hdr === moved_hdr))
            begin
                moved_seen++;
            end
        end
        else if (m_c1_kind != 0)
        begin
            check_rsp_hdr({tag, " c1 native hdr"}, m_c1_hdr, afu_c1_rx_hdr);
        end
        // Transmit side is wiring, compared with the row just driven
        check_req_hdr({tag, " c0 tx hdr"}, c0_tx_hdr_tbl[r], plat_c0_tx_hdr);
        check_req_hdr({tag, " c1 tx hdr"}, tx_hdr_tbl[r], plat_c1_tx_hdr);
        check_data({tag, " c1 tx data"}, tx_data_tbl[r], plat_c1_tx_data);
        check_bit({tag, " c0 tx rd_valid"}, tx_kind_tbl[r] == 1, plat_c0_tx_rd_valid);
        check_bit({tag, " c1 tx wr_valid"}, afu_c1_tx_wr_valid, plat_c1_tx_wr_valid);
        check_bit({tag, " c1 tx intr_valid"}, tx_kind_tbl[r] == 4, plat_c1_tx_intr_valid);
        check_bit({tag, " c0 alm_full"}, af_tbl[r][0], afu_c0_tx_alm_full);
        check_bit({tag, " c1 alm_full"},
                  af_tbl[r][1] || (m_count >= MAX_WRITE_REQS - ALMOST_FULL_THRESHOLD),
                  afu_c1_tx_alm_full);
    endtask

    // Watchdog sized from the table length
    initial
    begin
        #(($size(c0_kind_tbl) + 40) * 20);
        $display("Timeout: the run did not reach the end of the table");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        reset_n = 1'b0;
        build_table();
        apply_row($size(c0_kind_tbl) - 1);              // Last row is all idle
        plat_c1_tx_alm_full = 1'b1;                     // Must pass through during reset
        // Strobes held high so only the reset keeps the outputs low
        plat_c0_rx_wr_valid   = 1'b1;
        plat_c0_rx_rd_valid   = 1'b1;
        plat_c0_rx_cfg_valid  = 1'b1;
        plat_c0_rx_umsg_valid = 1'b1;
        plat_c0_rx_intr_valid = 1'b1;
        plat_c1_rx_wr_valid   = 1'b1;
        plat_c1_rx_intr_valid = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_bit("reset c0 strobes", 1'b0, afu_c0_rx_rd_valid | afu_c0_rx_cfg_valid |
                  afu_c0_rx_umsg_valid | afu_c0_rx_intr_valid);
        check_bit("reset c1 strobes", 1'b0, afu_c1_rx_wr_valid | afu_c1_rx_intr_valid);
        check_bit("reset c1 alm_full", plat_c1_tx_alm_full, afu_c1_tx_alm_full);
        reset_n = 1'b1;
        apply_row(0);
        for (int i = 1; i <= $size(c0_kind_tbl); i++)
        begin
            @(negedge clk);
            advance_model(i - 1);                       // Edge that just passed
            check_outputs(i - 1);
            if (i < $size(c0_kind_tbl))
            begin
                apply_row(i);
            end
        end
        if ((moved_q.size() != 0) || (moved_seen != moved_total))
        begin
            $display("Write responses missing on channel 1: %0d moved, %0d seen, %0d pending",
                     moved_total, moved_seen, moved_q.size());
            other_errors++;
        end
        if (UUT.u_chk.assert_errors != 0)
        begin
            $display("Assertion checker flagged %0d failures", UUT.u_chk.assert_errors);
            other_errors++;
        end
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0))
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- ccis_shim_chk.sv
module ccis_shim_chk
    import ccis_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      enq_en,                            // Registered channel 0 write strobe
    input logic      deq_en,                            // Replay into channel 1
    input t_wr_count occupancy,                         // FIFO level
    input logic      c0_rd_valid,
    input logic      c0_cfg_valid,
    input logic      c0_umsg_valid,
    input logic      c0_intr_valid,
    input logic      c1_wr_valid,
    input logic      c1_intr_valid
);

    int   assert_errors = 0;                            // Failure tally for the testbench
    logic c0_any;

    assign c0_any = c0_rd_valid || c0_cfg_valid || c0_umsg_valid || c0_intr_valid;

    // ------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------
    // A push without a pop needs a free slot
    fifo_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (enq_en && !deq_en) |-> (occupancy < t_wr_count'(MAX_WRITE_REQS)))
    else
    begin
        $error("Write response FIFO pushed while full");
        assert_errors++;
    end

    c0_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({c0_rd_valid, c0_cfg_valid, c0_umsg_valid, c0_intr_valid}))
    else
    begin
        $error("More than one AFU channel 0 strobe high");
        assert_errors++;
    end

    // Write completions are stripped from channel 0
    c0_write_stripped: assert property (@(posedge clk) disable iff (!reset_n)
        enq_en |-> !c0_any)
    else
    begin
        $error("Channel 0 write response leaked to the AFU");
        assert_errors++;
    end

    strobes_clear_after_reset: assert property (@(posedge clk)
        !reset_n |=> !(c0_any || c1_wr_valid || c1_intr_valid))
    else
    begin
        $error("AFU receive strobe high right after reset");
        assert_errors++;
    end

endmodule

bind ccis_wires_to_mpf ccis_shim_chk u_chk
(
    .clk           (clk),
    .reset_n       (reset_n),
    .enq_en        (c0_reg.wr_valid),
    .deq_en        (wr_rsp_deq),
    .occupancy     (u_wr_rsp_fifo.occupancy),
    .c0_rd_valid   (afu_c0_rx_rd_valid),
    .c0_cfg_valid  (afu_c0_rx_cfg_valid),
    .c0_umsg_valid (afu_c0_rx_umsg_valid),
    .c0_intr_valid (afu_c0_rx_intr_valid),
    .c1_wr_valid   (afu_c1_rx_wr_valid),
    .c1_intr_valid (afu_c1_rx_intr_valid)
);

//--- ccis_wires_to_mpf.sv
module ccis_wires_to_mpf
    import ccis_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    // Platform receive side
    input  t_rsp_hdr plat_c0_rx_hdr,
    input  t_cl_data plat_c0_rx_data,
    input  logic     plat_c0_rx_wr_valid,
    input  logic     plat_c0_rx_rd_valid,
    input  logic     plat_c0_rx_cfg_valid,
    input  logic     plat_c0_rx_umsg_valid,
    input  logic     plat_c0_rx_intr_valid,
    input  t_rsp_hdr plat_c1_rx_hdr,
    input  logic     plat_c1_rx_wr_valid,
    input  logic     plat_c1_rx_intr_valid,

    // Platform transmit side
    output t_req_hdr plat_c0_tx_hdr,
    output logic     plat_c0_tx_rd_valid,
    output t_req_hdr plat_c1_tx_hdr,
    output t_cl_data plat_c1_tx_data,
    output logic     plat_c1_tx_wr_valid,
    output logic     plat_c1_tx_intr_valid,
    input  logic     plat_c0_tx_alm_full,
    input  logic     plat_c1_tx_alm_full,

    // AFU transmit side
    input  t_req_hdr afu_c0_tx_hdr,
    input  logic     afu_c0_tx_rd_valid,
    input  t_req_hdr afu_c1_tx_hdr,
    input  t_cl_data afu_c1_tx_data,
    input  logic     afu_c1_tx_wr_valid,
    input  logic     afu_c1_tx_intr_valid,
    output logic     afu_c0_tx_alm_full,
    output logic     afu_c1_tx_alm_full,

    // AFU receive side
    output t_rsp_hdr afu_c0_rx_hdr,
    output t_cl_data afu_c0_rx_data,
    output logic     afu_c0_rx_rd_valid,
    output logic     afu_c0_rx_cfg_valid,
    output logic     afu_c0_rx_umsg_valid,
    output logic     afu_c0_rx_intr_valid,
    output t_rsp_hdr afu_c1_rx_hdr,
    output logic     afu_c1_rx_wr_valid,
    output logic     afu_c1_rx_intr_valid
);

    rsp_c0_if c0_reg ();                                // Registered channel 0 group

    t_rsp_hdr c1_hdr_q;                                 // Registered channel 1 group
    logic     c1_wr_valid_q;
    logic     c1_intr_valid_q;

    t_mdata   wr_rsp_first;                             // FIFO head tag
    logic     wr_rsp_not_empty;
    logic     wr_rsp_deq;

    // ------------------------------------------------------------
    // Input register stage
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        c0_reg.hdr  <= plat_c0_rx_hdr;                  // Payload is don't-care without a strobe
        c0_reg.data <= plat_c0_rx_data;
        c1_hdr_q    <= plat_c1_rx_hdr;

        if (!reset_n)
        begin
            c0_reg.wr_valid   <= 1'b0;
            c0_reg.rd_valid   <= 1'b0;
            c0_reg.cfg_valid  <= 1'b0;
            c0_reg.umsg_valid <= 1'b0;
            c0_reg.intr_valid <= 1'b0;
            c1_wr_valid_q     <= 1'b0;
            c1_intr_valid_q   <= 1'b0;
        end
        else
        begin
            c0_reg.wr_valid   <= plat_c0_rx_wr_valid;
            c0_reg.rd_valid   <= plat_c0_rx_rd_valid;
            c0_reg.cfg_valid  <= plat_c0_rx_cfg_valid;
            c0_reg.umsg_valid <= plat_c0_rx_umsg_valid;
            c0_reg.intr_valid <= plat_c0_rx_intr_valid;
            c1_wr_valid_q     <= plat_c1_rx_wr_valid;
            c1_intr_valid_q   <= plat_c1_rx_intr_valid;
        end
    end

    // Transmit path is pure wiring
    assign plat_c0_tx_hdr        = afu_c0_tx_hdr;
    assign plat_c0_tx_rd_valid   = afu_c0_tx_rd_valid;
    assign plat_c1_tx_hdr        = afu_c1_tx_hdr;
    assign plat_c1_tx_data       = afu_c1_tx_data;
    assign plat_c1_tx_wr_valid   = afu_c1_tx_wr_valid;
    assign plat_c1_tx_intr_valid = afu_c1_tx_intr_valid;
    assign afu_c0_tx_alm_full    = plat_c0_tx_alm_full;

    // ------------------------------------------------------------
    // Write response rerouting
    // ------------------------------------------------------------
    wr_credit_counter u_wr_credit_counter
    (
        .clk,
        .reset_n,
        .tx_wr_valid  (afu_c1_tx_wr_valid),
        .tx_req_type  (t_req_type'(afu_c1_tx_hdr[REQ_TYPE_MSB:REQ_TYPE_LSB])),
        .rx_wr_valid  (afu_c1_rx_wr_valid),           // Counts native and replayed writes
        .ext_alm_full (plat_c1_tx_alm_full),
        .alm_full     (afu_c1_tx_alm_full)
    );

    wr_rsp_fifo u_wr_rsp_fifo
    (
        .clk,
        .reset_n,
        .enq_en    (c0_reg.wr_valid),
        .enq_data  (c0_reg.hdr[MDATA_WIDTH-1:0]),
        .deq_en    (wr_rsp_deq),
        .first     (wr_rsp_first),
        .not_empty (wr_rsp_not_empty)
    );

    rsp_canonicalizer u_rsp_canonicalizer
    (
        .c0_in                (c0_reg.sink),
        .c1_hdr               (c1_hdr_q),
        .c1_wr_valid          (c1_wr_valid_q),
        .c1_intr_valid        (c1_intr_valid_q),
        .fifo_first           (wr_rsp_first),
        .fifo_not_empty       (wr_rsp_not_empty),
        .fifo_deq             (wr_rsp_deq),
        .afu_c0_rx_hdr,
        .afu_c0_rx_data,
        .afu_c0_rx_rd_valid,
        .afu_c0_rx_cfg_valid,
        .afu_c0_rx_umsg_valid,
        .afu_c0_rx_intr_valid,
        .afu_c1_rx_hdr,
        .afu_c1_rx_wr_valid,
        .afu_c1_rx_intr_valid
    );

endmodule

//--- rsp_canonicalizer.sv
module rsp_canonicalizer
    import ccis_pkg::*;
(
    rsp_c0_if.sink   c0_in,                             // Registered channel 0 responses
    input  t_rsp_hdr c1_hdr,                            // Registered channel 1 header
    input  logic     c1_wr_valid,
    input  logic     c1_intr_valid,
    input  t_mdata   fifo_first,                        // Oldest deferred write tag
    input  logic     fifo_not_empty,
    output logic     fifo_deq,                          // Tag was replayed this cycle

    output t_rsp_hdr afu_c0_rx_hdr,
    output t_cl_data afu_c0_rx_data,
    output logic     afu_c0_rx_rd_valid,
    output logic     afu_c0_rx_cfg_valid,
    output logic     afu_c0_rx_umsg_valid,
    output logic     afu_c0_rx_intr_valid,

    output t_rsp_hdr afu_c1_rx_hdr,
    output logic     afu_c1_rx_wr_valid,
    output logic     afu_c1_rx_intr_valid
);

    logic c1_idle;                                      // No native channel 1 response

    assign c1_idle = !c1_wr_valid && !c1_intr_valid;

    // ------------------------------------------------------------
    // Channel 0 forwarded without the write strobe
    // ------------------------------------------------------------
    assign afu_c0_rx_hdr        = c0_in.hdr;
    assign afu_c0_rx_data       = c0_in.data;
    assign afu_c0_rx_rd_valid   = c0_in.rd_valid;
    assign afu_c0_rx_cfg_valid  = c0_in.cfg_valid;
    assign afu_c0_rx_umsg_valid = c0_in.umsg_valid;
    assign afu_c0_rx_intr_valid = c0_in.intr_valid;

    // ------------------------------------------------------------
    // Channel 1 merge
    // ------------------------------------------------------------
    always_comb
    begin
        if (fifo_not_empty && c1_idle)
        begin
            // Replay a deferred write into the free slot
            afu_c1_rx_hdr                            = '0;
            afu_c1_rx_hdr[RSP_TYPE_MSB:RSP_TYPE_LSB] = RSP_WRLINE;
            afu_c1_rx_hdr[MDATA_WIDTH-1:0]           = fifo_first;
            afu_c1_rx_wr_valid                       = 1'b1;
            afu_c1_rx_intr_valid                     = 1'b0;
            fifo_deq                                 = 1'b1;
        end
        else
        begin
            afu_c1_rx_hdr        = c1_hdr;              // Native traffic has priority
            afu_c1_rx_wr_valid   = c1_wr_valid;
            afu_c1_rx_intr_valid = c1_intr_valid;
            fifo_deq             = 1'b0;
        end
    end

endmodule

//--- wr_rsp_fifo.sv
module wr_rsp_fifo
    import ccis_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   enq_en,                              // Push one write response
    input  t_mdata enq_data,                            // Its tag
    input  logic   deq_en,                              // Pop the oldest entry
    output t_mdata first,                               // Oldest entry, no read latency
    output logic   not_empty
);

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------
    t_mdata    mem [MAX_WRITE_REQS];                    // Tag storage, no reset needed
    t_wr_ptr   wr_ptr;                                  // Next free slot
    t_wr_ptr   rd_ptr;                                  // Oldest valid slot
    t_wr_count occupancy;                               // 0..MAX_WRITE_REQS entries
    logic      deq_ok;                                  // Pop that really removes an entry

    assign deq_ok    = deq_en && not_empty;             // Ignore a pop on an empty buffer
    assign not_empty = (occupancy != '0);
    assign first     = mem[rd_ptr];                     // Fall-through read

    // Write side
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointer and occupancy control
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;                // Wraps at the power-of-two depth
            end

            if (deq_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Push and pop together keep the level
            if (enq_en && !deq_ok)
            begin
                occupancy <= occupancy + 1'b1;
            end
            else if (!enq_en && deq_ok)
            begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

endmodule

//--- wr_credit_counter.sv
module wr_credit_counter
    import ccis_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      tx_wr_valid,                      // AFU channel 1 request strobe
    input  t_req_type tx_req_type,                      // Type field of that request
    input  logic      rx_wr_valid,                      // AFU-side channel 1 write response
    input  logic      ext_alm_full,                     // Platform channel 1 almost full
    output logic      alm_full                          // Throttled flag toward the AFU
);

    logic      wr_req;                                  // A write line is issued this cycle
    t_wr_count count;                                   // Writes still waiting for a response

    // Only the two write line flavors consume a response slot
    assign wr_req = tx_wr_valid &&
                    ((tx_req_type == REQ_WRLINE_I) || (tx_req_type == REQ_WRLINE_M));

    // ------------------------------------------------------------
    // Outstanding write count
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= '0;
        end
        else
        begin
            // Request and response in the same cycle cancel out
            if (wr_req && !rx_wr_valid)
            begin
                count <= count + 1'b1;
            end
            else if (!wr_req && rx_wr_valid)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Stop the AFU early so in-flight requests still fit the FIFO
    assign alm_full = ext_alm_full ||
                      (count >= t_wr_count'(MAX_WRITE_REQS - ALMOST_FULL_THRESHOLD));

endmodule

//--- rsp_c0_if.sv
interface rsp_c0_if
    import ccis_pkg::*;
    ();

    // ------------------------------------------------------------
    // One registered channel 0 response group
    // ------------------------------------------------------------
    t_rsp_hdr hdr;                                      // Valid only with a strobe
    t_cl_data data;                                     // Read data, same cycle as hdr

    // Strobes are mutually exclusive
    logic     wr_valid;                                 // Write completion
    logic     rd_valid;                                 // Read completion with data
    logic     cfg_valid;                                // CSR write
    logic     umsg_valid;                               // Unordered message
    logic     intr_valid;                               // Interrupt completion

    // Input register stage in the top
    modport source
    (
        output hdr, data,
        output wr_valid, rd_valid, cfg_valid, umsg_valid, intr_valid
    );

    // Canonicalizer, no back-pressure path
    modport sink
    (
        input hdr, data,
        input wr_valid, rd_valid, cfg_valid, umsg_valid, intr_valid
    );

endinterface

//--- ccis_pkg.sv
package ccis_pkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    localparam int MDATA_WIDTH   = 14;                  // Request tag echoed in responses
    localparam int ADDR_WIDTH    = 32;                  // Cache line address
    localparam int CL_DATA_WIDTH = 64;                  // Narrow stand-in for a full line
    localparam int TYPE_WIDTH    = 4;                   // Request and response type code

    localparam int RSP_HDR_WIDTH = TYPE_WIDTH + MDATA_WIDTH;
    localparam int REQ_HDR_WIDTH = TYPE_WIDTH + ADDR_WIDTH + MDATA_WIDTH;

    // Response header is {type, mdata}
    localparam int RSP_TYPE_LSB = MDATA_WIDTH;
    localparam int RSP_TYPE_MSB = RSP_TYPE_LSB + TYPE_WIDTH - 1;

    // Request header is {type, address, mdata}
    localparam int REQ_TYPE_LSB = ADDR_WIDTH + MDATA_WIDTH;
    localparam int REQ_TYPE_MSB = REQ_TYPE_LSB + TYPE_WIDTH - 1;

    // ------------------------------------------------------------
    // Write response buffering
    // ------------------------------------------------------------
    localparam int MAX_WRITE_REQS        = 16;          // FIFO depth and write limit
    localparam int ALMOST_FULL_THRESHOLD = 4;           // Slack kept free below the limit
    localparam int WR_PTR_WIDTH          = $clog2(MAX_WRITE_REQS);
    localparam int WR_COUNT_WIDTH        = WR_PTR_WIDTH + 1;    // Must hold 0..MAX

    typedef logic [MDATA_WIDTH-1:0]    t_mdata;
    typedef logic [ADDR_WIDTH-1:0]     t_addr;
    typedef logic [CL_DATA_WIDTH-1:0]  t_cl_data;
    typedef logic [RSP_HDR_WIDTH-1:0]  t_rsp_hdr;
    typedef logic [REQ_HDR_WIDTH-1:0]  t_req_hdr;
    typedef logic [WR_COUNT_WIDTH-1:0] t_wr_count;
    typedef logic [WR_PTR_WIDTH-1:0]   t_wr_ptr;       // FIFO slot index

    // Request codes on the transmit side
    typedef enum logic [TYPE_WIDTH-1:0]
    {
        REQ_WRLINE_I = 4'h1,                            // Write line, invalidate
        REQ_WRLINE_M = 4'h2,                            // Write line, keep modified
        REQ_RDLINE   = 4'h4,
        REQ_INTR     = 4'h8
    } t_req_type;

    // Response codes on the receive side
    typedef enum logic [TYPE_WIDTH-1:0]
    {
        RSP_CFG    = 4'h0,                              // CSR write
        RSP_WRLINE = 4'h1,
        RSP_RDLINE = 4'h4,
        RSP_INTR   = 4'h8,
        RSP_UMSG   = 4'hf
    } t_rsp_type;

endpackage
